//--- Makefile
# Verilator flow for the stepper motor controller

TOP = tb_step_motor_controller

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f sources.f --top-module $(TOP)

sim:
	verilator --binary --assert -Wno-fatal -f sources.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- design/clock_prescaler.sv
/*
  Fractional clock prescaler
  Emits multiplier ticks for every divider clock cycles
*/
`timescale 1ns/1ps
`default_nettype none

module clock_prescaler #(
  parameter int PSIZE = 32  // Accumulator width
) (
  input  wire             clk,
  input  wire             rst_n,
  input  wire             enable_i,      // Low clears the accumulator
  input  wire [PSIZE-1:0] multiplier_i,
  input  wire [PSIZE-1:0] divider_i,
  output logic            tick_o         // One cycle pulse
);

  logic [PSIZE-1:0] acc;
  logic [PSIZE:0]   sum;                 // One extra bit for carry
  logic             wrap;

  assign sum  = {1'b0, acc} + {1'b0, multiplier_i};
  assign wrap = (sum >= {1'b0, divider_i});

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc    <= '0;
      tick_o <= 1'b0;
    end else if (!enable_i) begin
      acc    <= '0;
      tick_o <= 1'b0;
    end else begin
      if (wrap) begin
        acc <= sum[PSIZE-1:0] - divider_i;  // Keep the fractional remainder
      end else begin
        acc <= sum[PSIZE-1:0];
      end
      tick_o <= wrap;
    end
  end

endmodule

`default_nettype wire

//--- design/pwm_generator.sv
/*
  PWM generator
  Counter advanced by the prescaler tick, high while at or below the duty
*/
`timescale 1ns/1ps
`default_nettype none

module pwm_generator (
  input  wire                             clk,
  input  wire                             rst_n,
  input  wire                             enable_i,
  input  wire [stepper_pkg::DUTY_W-1:0]   duty_cycle_i,
  input  wire                             tick_i,       // PWM resolution tick
  output logic                            start_o,      // Start of PWM period
  output logic                            pwm_o
);

  logic [stepper_pkg::DUTY_W-1:0] count;
  logic [stepper_pkg::DUTY_W-1:0] count_next;
  logic                           wrap;

  assign count_next = count + 1'b1;

  // Tick moves the counter from the upper half back to zero
  assign wrap = tick_i & count[stepper_pkg::DUTY_W-1] & ~count_next[stepper_pkg::DUTY_W-1];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count   <= '0;
      start_o <= 1'b0;
      pwm_o   <= 1'b0;
    end else if (!enable_i) begin
      count   <= '0;
      start_o <= 1'b0;
      pwm_o   <= 1'b0;
    end else begin
      if (tick_i) begin
        count <= count_next;
      end
      start_o <= wrap;
      pwm_o   <= (count <= duty_cycle_i);  // duty+1 high slots per period
    end
  end

endmodule

`default_nettype wire

//--- design/step_motor_controller.sv
/*
  Stepper motor controller top level
  Register block, prescaler, PWM and step sequencer on a Wishbone slave
*/
`timescale 1ns/1ps
`default_nettype none

module step_motor_controller #(
  parameter int PSIZE = 32,  // Prescaler width
  parameter int DSIZE = 16   // Step period width
) (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          wbs_cyc_i,
  input  wire                          wbs_stb_i,
  input  wire [stepper_pkg::WB_W-1:0]  wbs_adr_i,
  input  wire                          wbs_we_i,
  input  wire [stepper_pkg::WB_W-1:0]  wbs_dat_i,
  output wire [stepper_pkg::WB_W-1:0]  wbs_dat_o,
  output wire                          wbs_ack_o,
  output wire                          motor_a1_o,
  output wire                          motor_a2_o,
  output wire                          motor_b1_o,
  output wire                          motor_b2_o
);

  logic                              controller_en;
  logic [PSIZE-1:0]                  multiplier;
  logic [PSIZE-1:0]                  divider;
  logic [stepper_pkg::DUTY_W-1:0]    duty_cycle;
  stepper_pkg::motor_type_e          motor_type;
  stepper_pkg::drive_mode_e          drive_mode;
  logic                              direction;
  logic [DSIZE-1:0]                  period;
  logic                              run;
  logic                              tick;
  logic                              pwm_start;
  logic                              pwm;
  logic                              step_strobe;   // Back to the step counter

  stepper_regs #(
    .PSIZE (PSIZE),
    .DSIZE (DSIZE)
  ) regs_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .wbs_cyc_i       (wbs_cyc_i),
    .wbs_stb_i       (wbs_stb_i),
    .wbs_adr_i       (wbs_adr_i),
    .wbs_we_i        (wbs_we_i),
    .wbs_dat_i       (wbs_dat_i),
    .wbs_dat_o       (wbs_dat_o),
    .wbs_ack_o       (wbs_ack_o),
    .step_strobe_i   (step_strobe),
    .controller_en_o (controller_en),
    .multiplier_o    (multiplier),
    .divider_o       (divider),
    .duty_cycle_o    (duty_cycle),
    .motor_type_o    (motor_type),
    .drive_mode_o    (drive_mode),
    .direction_o     (direction),
    .period_o        (period),
    .run_o           (run)
  );

  clock_prescaler #(
    .PSIZE (PSIZE)
  ) prescaler_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (controller_en),
    .multiplier_i (multiplier),
    .divider_i    (divider),
    .tick_o       (tick)
  );

  pwm_generator pwm_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (controller_en),
    .duty_cycle_i (duty_cycle),
    .tick_i       (tick),
    .start_o      (pwm_start),
    .pwm_o        (pwm)
  );

  step_sequencer #(
    .DSIZE (DSIZE)
  ) sequencer_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .enable_i      (controller_en),
    .motor_type_i  (motor_type),
    .drive_mode_i  (drive_mode),
    .direction_i   (direction),
    .period_i      (period),
    .run_i         (run),
    .pwm_start_i   (pwm_start),
    .pwm_i         (pwm),
    .step_strobe_o (step_strobe),
    .motor_a1_o    (motor_a1_o),
    .motor_a2_o    (motor_a2_o),
    .motor_b1_o    (motor_b1_o),
    .motor_b2_o    (motor_b2_o)
  );

endmodule

`default_nettype wire

//--- design/step_sequencer.sv
/*
  Step sequencer
  Times steps in PWM periods, walks the phase table and drives the windings
*/
`timescale 1ns/1ps
`default_nettype none

module step_sequencer #(
  parameter int DSIZE = 16  // Step period counter width
) (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire                       enable_i,
  input  wire stepper_pkg::motor_type_e motor_type_i,
  input  wire stepper_pkg::drive_mode_e drive_mode_i,
  input  wire                       direction_i,     // 0 counts phases up
  input  wire [DSIZE-1:0]           period_i,
  input  wire                       run_i,
  input  wire                       pwm_start_i,
  input  wire                       pwm_i,
  output logic                      step_strobe_o,   // One pulse per step
  output logic                      motor_a1_o,
  output logic                      motor_a2_o,
  output logic                      motor_b1_o,
  output logic                      motor_b2_o
);

  logic [DSIZE-1:0] delay;
  logic [2:0]       phase;
  logic [2:0]       phase_idx;
  logic [3:0]       pattern;       // b2 b1 a2 a1
  logic             pwm_q;
  logic             step;

  assign step = run_i & pwm_start_i & (delay >= period_i);

  // Full step uses only the even table entries
  assign phase_idx = {phase[2:1], phase[0] & (drive_mode_i == stepper_pkg::DRIVE_HALF)};
  assign pattern   = stepper_pkg::PHASE_TABLE[phase_idx];

  ////////////////////////////////////////
  // Step timing and phase
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n || !enable_i) begin
      delay         <= '0;
      phase         <= 3'd0;
      step_strobe_o <= 1'b0;
    end else begin
      if (!run_i) begin
        delay <= '0;
      end else if (pwm_start_i) begin
        if (step) begin
          delay <= '0;
          if (!direction_i) begin
            phase <= phase + 3'd1;
          end else begin
            phase <= phase - 3'd1;
          end
        end else begin
          delay <= delay + 1'b1;
        end
      end
      step_strobe_o <= step;
    end
  end

  ////////////////////////////////////////
  // Winding outputs
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n || !enable_i) begin
      pwm_q      <= 1'b0;
      motor_a1_o <= 1'b0;
      motor_a2_o <= 1'b0;
      motor_b1_o <= 1'b0;
      motor_b2_o <= 1'b0;
    end else begin
      pwm_q      <= pwm_i;                  // Aligns PWM with the phase lookup
      motor_a1_o <= pattern[0] & pwm_q;
      motor_b2_o <= pattern[3] & pwm_q;
      if (motor_type_i == stepper_pkg::MOTOR_UNIPOLAR) begin
        motor_a2_o <= pattern[1] & pwm_q;
        motor_b1_o <= pattern[2] & pwm_q;
      end else begin
        motor_a2_o <= pattern[2] & pwm_q;   // Bipolar swaps the middle bits
        motor_b1_o <= pattern[1] & pwm_q;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/stepper_pkg.sv
/*
  Stepper controller shared definitions
  Bus widths, register map, drive modes and winding pattern table
*/
`default_nettype none

package stepper_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////
  localparam int WB_W     = 32;  // Wishbone data and address
  localparam int DUTY_W   = 8;   // PWM duty and counter
  localparam int CYCLES_W = 24;  // Remaining step counter

  ////////////////////////////////////////
  // Register map, word address bits 4:2
  ////////////////////////////////////////
  typedef enum logic [2:0] {
    REG_CONFIG = 3'd0,  // Enable, motor type, drive mode, duty
    REG_MULT   = 3'd1,  // Prescaler multiplier
    REG_DIV    = 3'd2,  // Prescaler divider
    REG_PERIOD = 3'd3,  // Step period in PWM periods
    REG_STEP   = 3'd4   // Run, direction, free, step count
  } reg_addr_e;

  typedef enum logic {
    MOTOR_UNIPOLAR = 1'b0,
    MOTOR_BIPOLAR  = 1'b1
  } motor_type_e;

  typedef enum logic {
    DRIVE_FULL = 1'b0,
    DRIVE_HALF = 1'b1
  } drive_mode_e;

  // Winding patterns, bit order b2 b1 a2 a1
  localparam logic [3:0] PHASE_TABLE [8] = '{
    4'b1001, 4'b0001, 4'b0011, 4'b0010,
    4'b0110, 4'b0100, 4'b1100, 4'b1000
  };

endpackage

`default_nettype wire

//--- design/stepper_regs.sv
/*
  Stepper register block
  Wishbone slave with read-back, run control and remaining step counter
*/
`timescale 1ns/1ps
`default_nettype none

module stepper_regs #(
  parameter int PSIZE = 32,  // Prescaler width
  parameter int DSIZE = 16   // Step period width
) (
  input  wire                                clk,
  input  wire                                rst_n,
  input  wire                                wbs_cyc_i,
  input  wire                                wbs_stb_i,
  input  wire [stepper_pkg::WB_W-1:0]        wbs_adr_i,
  input  wire                                wbs_we_i,
  input  wire [stepper_pkg::WB_W-1:0]        wbs_dat_i,
  output logic [stepper_pkg::WB_W-1:0]       wbs_dat_o,
  output logic                               wbs_ack_o,
  input  wire                                step_strobe_i,
  output logic                               controller_en_o,
  output logic [PSIZE-1:0]                   multiplier_o,
  output logic [PSIZE-1:0]                   divider_o,
  output logic [stepper_pkg::DUTY_W-1:0]     duty_cycle_o,
  output stepper_pkg::motor_type_e           motor_type_o,
  output stepper_pkg::drive_mode_e           drive_mode_o,
  output logic                               direction_o,
  output logic [DSIZE-1:0]                   period_o,
  output logic                               run_o
);

  stepper_pkg::reg_addr_e             addr;
  logic                               req;
  logic                               wr;
  logic                               free;     // Ignore the step count
  logic [stepper_pkg::CYCLES_W-1:0]   cycles;
  logic [stepper_pkg::WB_W-1:0]       rd_data;

  assign addr = stepper_pkg::reg_addr_e'(wbs_adr_i[4:2]);
  assign req  = wbs_cyc_i & wbs_stb_i & ~wbs_ack_o;  // New access only
  assign wr   = req & wbs_we_i;

  ////////////////////////////////////////
  // Read mux and bus response
  ////////////////////////////////////////
  always_comb begin
    rd_data = '0;
    case (addr)
      stepper_pkg::REG_CONFIG: begin
        rd_data[31] = controller_en_o;
        rd_data[30] = motor_type_o;
        rd_data[29] = drive_mode_o;
        rd_data[stepper_pkg::DUTY_W-1:0] = duty_cycle_o;
      end
      stepper_pkg::REG_MULT:   rd_data[PSIZE-1:0] = multiplier_o;
      stepper_pkg::REG_DIV:    rd_data[PSIZE-1:0] = divider_o;
      stepper_pkg::REG_PERIOD: rd_data[DSIZE-1:0] = period_o;
      stepper_pkg::REG_STEP: begin
        rd_data[31] = run_o;
        rd_data[30] = direction_o;
        rd_data[29] = free;
        rd_data[stepper_pkg::CYCLES_W-1:0] = cycles;  // Live count
      end
      default: rd_data = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wbs_ack_o <= 1'b0;
    end else begin
      wbs_ack_o <= req;
    end
  end

  // Captured before any write lands
  always_ff @(posedge clk) begin
    if (req) begin
      wbs_dat_o <= rd_data;
    end
  end

  ////////////////////////////////////////
  // Configuration registers
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      controller_en_o <= 1'b0;
      motor_type_o    <= stepper_pkg::MOTOR_UNIPOLAR;
      drive_mode_o    <= stepper_pkg::DRIVE_FULL;
      duty_cycle_o    <= '0;
      multiplier_o    <= '0;
      divider_o       <= '0;
      period_o        <= '0;
    end else if (wr) begin
      case (addr)
        stepper_pkg::REG_CONFIG: begin
          controller_en_o <= wbs_dat_i[31];
          motor_type_o    <= stepper_pkg::motor_type_e'(wbs_dat_i[30]);
          drive_mode_o    <= stepper_pkg::drive_mode_e'(wbs_dat_i[29]);
          duty_cycle_o    <= wbs_dat_i[stepper_pkg::DUTY_W-1:0];
        end
        stepper_pkg::REG_MULT:   multiplier_o <= wbs_dat_i[PSIZE-1:0];
        stepper_pkg::REG_DIV:    divider_o    <= wbs_dat_i[PSIZE-1:0];
        stepper_pkg::REG_PERIOD: period_o     <= wbs_dat_i[DSIZE-1:0];
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////
  // Run control and step count
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      run_o       <= 1'b0;
      direction_o <= 1'b0;
      free        <= 1'b0;
      cycles      <= '0;
    end else if (wr && (addr == stepper_pkg::REG_STEP)) begin
      run_o       <= wbs_dat_i[31];
      direction_o <= wbs_dat_i[30];
      free        <= wbs_dat_i[29];
      cycles      <= wbs_dat_i[stepper_pkg::CYCLES_W-1:0];  // Whole count loads
    end else if (step_strobe_i) begin
      if (cycles != '0) begin
        if (run_o) begin
          cycles <= cycles - 1'b1;
        end
      end else if (!free) begin
        run_o <= 1'b0;  // Last step taken at zero
      end
    end
  end

endmodule

`default_nettype wire

//--- sources.f
design/stepper_pkg.sv
design/clock_prescaler.sv
design/pwm_generator.sv
design/step_sequencer.sv
design/stepper_regs.sv
design/step_motor_controller.sv
test/tb_step_motor_controller.sv

//--- test/tb_step_motor_controller.sv
/*
  Testbench for the stepper motor controller
  Register read-back, phase sequences, step count, PWM duty and disable
*/
`timescale 1ns/1ps
`default_nettype none

module tb_step_motor_controller;

  localparam int          PSIZE     = 32;
  localparam int          DSIZE     = 16;
  localparam logic [31:0] SEED      = 32'h7a15_8329;
  localparam int          ACK_LIMIT = 16;  // Cycles allowed for ack

  logic        clk;
  logic        rst_n;
  logic        wbs_cyc_i;
  logic        wbs_stb_i;
  logic [31:0] wbs_adr_i;
  logic        wbs_we_i;
  logic [31:0] wbs_dat_i;
  wire  [31:0] wbs_dat_o;
  wire         wbs_ack_o;
  wire         motor_a1_o;
  wire         motor_a2_o;
  wire         motor_b1_o;
  wire         motor_b2_o;

  int          checks;
  int          errors;
  int          timeouts;
  int          pattern_checks;   // Owned by the monitor
  int          pattern_errors;
  int          change_count;
  logic        watch_en;
  logic [3:0]  last_pat;
  logic [3:0]  expected_q [$];   // Patterns the monitor expects next

  step_motor_controller #(
    .PSIZE (PSIZE),
    .DSIZE (DSIZE)
  ) dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .wbs_cyc_i  (wbs_cyc_i),
    .wbs_stb_i  (wbs_stb_i),
    .wbs_adr_i  (wbs_adr_i),
    .wbs_we_i   (wbs_we_i),
    .wbs_dat_i  (wbs_dat_i),
    .wbs_dat_o  (wbs_dat_o),
    .wbs_ack_o  (wbs_ack_o),
    .motor_a1_o (motor_a1_o),
    .motor_a2_o (motor_a2_o),
    .motor_b1_o (motor_b1_o),
    .motor_b2_o (motor_b2_o)
  );

  always #10 clk = ~clk;

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  // Returns b2 b1 a2 a1
  function automatic logic [3:0] expected_outputs(input logic [2:0] phase,
                                                  input stepper_pkg::drive_mode_e mode,
                                                  input stepper_pkg::motor_type_e mtype);
    logic [2:0] idx;
    logic [3:0] pat;
    idx = phase;
    if (mode == stepper_pkg::DRIVE_FULL) begin
      idx[0] = 1'b0;                          // Full step sits on even entries
    end
    pat = stepper_pkg::PHASE_TABLE[idx];
    if (mtype == stepper_pkg::MOTOR_UNIPOLAR) begin
      return pat;
    end
    return {pat[3], pat[1], pat[2], pat[0]};  // Middle windings swapped
  endfunction

  function automatic logic [31:0] field_mask(input int width);
    if (width >= 32) begin
      return 32'hFFFF_FFFF;
    end
    return (32'h1 << width) - 32'h1;
  endfunction

  function automatic logic [31:0] config_word(input logic en, input logic mtype,
                                              input logic mode, input logic [7:0] duty);
    return {en, mtype, mode, 21'd0, duty};
  endfunction

  function automatic logic [31:0] step_word(input logic run, input logic dir,
                                            input logic free, input logic [23:0] count);
    return {run, dir, free, 5'd0, count};
  endfunction

  function automatic logic [3:0] motor_outputs();
    return {motor_b2_o, motor_b1_o, motor_a2_o, motor_a1_o};
  endfunction

  ////////////////////////////////////////
  // Pattern monitor
  ////////////////////////////////////////
  always @(negedge clk) begin : pattern_monitor
    logic [3:0] now_pat;
    logic [3:0] exp_pat;
    now_pat = motor_outputs();
    if (now_pat != last_pat) begin
      if (watch_en && now_pat != 4'b0000) begin
        change_count++;
        if (expected_q.size() > 0) begin
          exp_pat = expected_q.pop_front();
          pattern_checks++;
          assert (now_pat == exp_pat) else begin
            pattern_errors++;
            $display("FAILED at %0t ns: motor pattern %b, expected %b",
                     $time, now_pat, exp_pat);
          end
        end
      end
      last_pat = now_pat;
    end
  end

  ////////////////////////////////////////
  // Checks and bus tasks
  ////////////////////////////////////////
  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED at %0t ns: %s was %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("ERROR at %0t ns: timed out waiting for %s", $time, what);
  endtask

  task automatic bus_access(input stepper_pkg::reg_addr_e addr, input logic we,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int   wait_cycles;
    logic acked;
    wait_cycles = 0;
    acked       = 1'b0;
    rdata       = '0;
    @(negedge clk);
    wbs_cyc_i = 1'b1;
    wbs_stb_i = 1'b1;
    wbs_we_i  = we;
    wbs_adr_i = {27'd0, addr, 2'b00};
    wbs_dat_i = wdata;
    while (!acked && wait_cycles < ACK_LIMIT) begin
      @(negedge clk);
      wait_cycles++;
      if (wbs_ack_o) begin
        acked = 1'b1;
        rdata = wbs_dat_o;
      end
    end
    wbs_cyc_i = 1'b0;  // Drop the request in the ack cycle
    wbs_stb_i = 1'b0;
    wbs_we_i  = 1'b0;
    if (!acked) begin
      report_timeout("the bus acknowledge");
    end else begin
      check_value("ack latency in cycles", wait_cycles, 32'd1);
      @(negedge clk);
      check_value("ack after one cycle", {31'd0, wbs_ack_o}, 32'd0);
    end
  endtask

  task automatic bus_write(input stepper_pkg::reg_addr_e addr, input logic [31:0] data);
    logic [31:0] unused;
    bus_access(addr, 1'b1, data, unused);
  endtask

  task automatic bus_read(input stepper_pkg::reg_addr_e addr, output logic [31:0] data);
    bus_access(addr, 1'b0, 32'd0, data);
  endtask

  task automatic stop_motor();
    bus_write(stepper_pkg::REG_CONFIG, 32'd0);  // Also returns the phase to 0
    bus_write(stepper_pkg::REG_STEP, 32'd0);
  endtask

  // One tick per clock, step on every PWM period
  task automatic set_unity_rate();
    bus_write(stepper_pkg::REG_MULT, 32'd1);
    bus_write(stepper_pkg::REG_DIV, 32'd1);
    bus_write(stepper_pkg::REG_PERIOD, 32'd0);
  endtask

  task automatic wait_outputs_on(input int limit);
    int n;
    n = 0;
    while (motor_outputs() == 4'b0000 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (motor_outputs() == 4'b0000) begin
      report_timeout("the motor outputs to turn on");
    end
    @(negedge clk);
  endtask

  task automatic wait_patterns_seen(input int limit);
    int n;
    n = 0;
    while (expected_q.size() != 0 && n < limit) begin
      @(negedge clk);
      n++;
    end
    if (expected_q.size() != 0) begin
      report_timeout("the expected phase patterns");
      expected_q.delete();
    end
  endtask

  ////////////////////////////////////////
  // Test sequences
  ////////////////////////////////////////
  task automatic check_readback();
    logic [31:0] data;
    logic [31:0] got;
    for (int i = 0; i < 5; i++) begin
      bus_read(stepper_pkg::reg_addr_e'(i), got);
      check_value("register after reset", got, 32'd0);
    end
    for (int i = 0; i < 4; i++) begin
      data = $urandom();
      bus_write(stepper_pkg::REG_CONFIG, data);
      bus_read(stepper_pkg::REG_CONFIG, got);
      check_value("CONFIG read-back", got, data & 32'hE000_00FF);
      data = $urandom();
      bus_write(stepper_pkg::REG_MULT, data);
      bus_read(stepper_pkg::REG_MULT, got);
      check_value("MULT read-back", got, data & field_mask(PSIZE));
      data = $urandom();
      bus_write(stepper_pkg::REG_DIV, data);
      bus_read(stepper_pkg::REG_DIV, got);
      check_value("DIV read-back", got, data & field_mask(PSIZE));
      data = $urandom();
      bus_write(stepper_pkg::REG_PERIOD, data);
      bus_read(stepper_pkg::REG_PERIOD, got);
      check_value("PERIOD read-back", got, data & field_mask(DSIZE));
      data = $urandom() & 32'h7FFF_FFFF;  // Run stays off
      bus_write(stepper_pkg::REG_STEP, data);
      bus_read(stepper_pkg::REG_STEP, got);
      check_value("STEP read-back", got, data & 32'h60FF_FFFF);
    end
    stop_motor();
  endtask

  task automatic check_full_step();
    logic [2:0] ph;
    stop_motor();
    set_unity_rate();
    bus_write(stepper_pkg::REG_STEP, step_word(1'b1, 1'b0, 1'b1, 24'd0));
    ph = 3'd0;
    for (int k = 0; k < 8; k++) begin
      expected_q.push_back(expected_outputs(ph, stepper_pkg::DRIVE_FULL,
                                            stepper_pkg::MOTOR_UNIPOLAR));
      ph = ph + 3'd2;
    end
    watch_en = 1'b1;
    bus_write(stepper_pkg::REG_CONFIG, config_word(1'b1, 1'b0, 1'b0, 8'hFF));
    wait_patterns_seen(5000);
    watch_en = 1'b0;
    stop_motor();
  endtask

  task automatic check_half_step_reverse();
    logic [2:0] ph;
    stop_motor();
    set_unity_rate();
    bus_write(stepper_pkg::REG_STEP, step_word(1'b1, 1'b1, 1'b1, 24'd0));
    ph = 3'd0;
    for (int k = 0; k < 10; k++) begin
      expected_q.push_back(expected_outputs(ph, stepper_pkg::DRIVE_HALF,
                                            stepper_pkg::MOTOR_BIPOLAR));
      ph = ph - 3'd1;
    end
    watch_en = 1'b1;
    bus_write(stepper_pkg::REG_CONFIG, config_word(1'b1, 1'b1, 1'b1, 8'hFF));
    wait_patterns_seen(4000);
    watch_en = 1'b0;
    stop_motor();
  endtask

  task automatic check_step_count();
    int          n;
    int          polls;
    int          start_count;
    logic [2:0]  ph;
    logic [31:0] got;
    n = $urandom() % 16;
    stop_motor();
    set_unity_rate();
    bus_write(stepper_pkg::REG_CONFIG, config_word(1'b1, 1'b0, 1'b1, 8'hFF));
    wait_outputs_on(64);
    start_count = change_count;
    ph = 3'd0;
    for (int k = 0; k < n + 1; k++) begin
      ph = ph + 3'd1;
      expected_q.push_back(expected_outputs(ph, stepper_pkg::DRIVE_HALF,
                                            stepper_pkg::MOTOR_UNIPOLAR));
    end
    watch_en = 1'b1;
    bus_write(stepper_pkg::REG_STEP, step_word(1'b1, 1'b0, 1'b0, 24'(n)));
    polls = 0;
    got   = 32'h8000_0000;
    while (got[31] && polls < 3000) begin
      bus_read(stepper_pkg::REG_STEP, got);
      polls++;
    end
    if (got[31]) begin
      report_timeout("run to clear after the step count");
    end
    repeat (600) @(negedge clk);  // Over two PWM periods with no step
    watch_en = 1'b0;
    check_value("output pattern changes", change_count - start_count, n + 1);
    check_value("unseen patterns", expected_q.size(), 0);
    bus_read(stepper_pkg::REG_STEP, got);
    check_value("remaining steps", {8'd0, got[23:0]}, 32'd0);
    expected_q.delete();
    stop_motor();
  endtask

  task automatic check_duty();
    int         duty;
    int         high_cycles;
    logic [3:0] pat;
    pat = expected_outputs(3'd0, stepper_pkg::DRIVE_FULL, stepper_pkg::MOTOR_UNIPOLAR);
    for (int r = 0; r < 3; r++) begin
      duty = $urandom() % 256;
      stop_motor();
      set_unity_rate();
      bus_write(stepper_pkg::REG_CONFIG, config_word(1'b1, 1'b0, 1'b0, 8'(duty)));
      repeat (8) @(negedge clk);  // PWM pipeline fill
      high_cycles = 0;
      repeat (256) begin
        @(negedge clk);
        if (motor_a1_o) begin
          high_cycles++;
        end
      end
      check_value("a1 high cycles", high_cycles, pat[0] ? duty + 1 : 0);
    end
    stop_motor();
  endtask

  task automatic check_disable();
    int         n;
    logic [3:0] seen;
    stop_motor();
    set_unity_rate();
    bus_write(stepper_pkg::REG_STEP, step_word(1'b1, 1'b0, 1'b1, 24'd0));
    bus_write(stepper_pkg::REG_CONFIG, config_word(1'b1, 1'b1, 1'b1, 8'hFF));
    wait_outputs_on(64);
    repeat (300) @(negedge clk);
    bus_write(stepper_pkg::REG_CONFIG, config_word(1'b0, 1'b1, 1'b1, 8'hFF));
    n = 0;
    // Write landed two clock edges earlier, one more makes three
    while (motor_outputs() != 4'b0000 && n < 1) begin
      @(negedge clk);
      n++;
    end
    check_value("outputs after disable", {28'd0, motor_outputs()}, 32'd0);
    seen = 4'b0000;
    repeat (64) begin
      @(negedge clk);
      seen = seen | motor_outputs();
    end
    check_value("outputs held low", {28'd0, seen}, 32'd0);
    stop_motor();
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////
  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    wbs_cyc_i      = 1'b0;
    wbs_stb_i      = 1'b0;
    wbs_adr_i      = 32'd0;
    wbs_we_i       = 1'b0;
    wbs_dat_i      = 32'd0;
    checks         = 0;
    errors         = 0;
    timeouts       = 0;
    pattern_checks = 0;
    pattern_errors = 0;
    change_count   = 0;
    watch_en       = 1'b0;
    last_pat       = 4'b0000;
    void'($urandom(SEED));
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    check_readback();
    check_full_step();
    check_half_step_reverse();
    check_step_count();
    check_duty();
    check_disable();

    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks + pattern_checks,
             errors + pattern_errors, timeouts);
    if (errors == 0 && pattern_errors == 0 && timeouts == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
